/* rtl/cache_pkg.sv */
package cache_pkg;

  // fixed field positions of the virtual address
  localparam int VTAG_LSB    = 18;
  localparam int VTAG_BITS   = 14;
  localparam int TLB_IDX_LSB = 10;
  localparam int TLB_IDX_BITS = 8;
  localparam int WORD_LSB    = 2;

  // physical side
  localparam int PAGE_BITS  = 10;
  localparam int FRAME_BITS = 16;

  typedef logic [31:0] vaddr_t;

  // frame number doubles as the cache tag
  typedef logic [FRAME_BITS-1:0] line_tag_t;

  typedef struct packed {
    line_tag_t frame;
    logic [PAGE_BITS-1:0] offset;
  } paddr_t;

  typedef struct packed {
    vaddr_t addr;
    logic write;
    logic [31:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic fault;
  } cpu_rsp_t;

  typedef struct packed {
    logic [VTAG_BITS-1:0] vtag;
    line_tag_t frame;
  } tlb_entry_t;

  typedef struct packed {
    logic [TLB_IDX_BITS-1:0] index;
    tlb_entry_t entry;
  } tlb_load_t;

  typedef struct packed {
    paddr_t addr;
    logic write;
    logic [31:0] wdata;
  } mem_req_t;

  // one cycle after the lookup address
  typedef struct packed {
    logic hit;
    logic fault;
    paddr_t paddr;
    logic [31:0] rdata;
  } lookup_t;

endpackage

/* rtl/sync_ram.sv */
`timescale 1ns/1ps

module sync_ram #(
  parameter type data_t = logic [31:0],
  parameter int DEPTH = 256
) (
  input  logic                     CPU_CLK,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output data_t                    rdata,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  data_t                    wdata
);

  data_t mem [DEPTH];

  // write port
  always_ff @(posedge CPU_CLK)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, old data on a colliding write
  always_ff @(posedge CPU_CLK)
  begin
    rdata <= mem[raddr];
  end

endmodule

/* rtl/tlb.sv */
`timescale 1ns/1ps

module tlb #(
  parameter int TLB_ENTRIES = 256
) (
  input  logic                 CPU_CLK,
  input  logic                 RST,
  input  cache_pkg::vaddr_t    lookup_vaddr,
  input  logic                 load_we,
  input  cache_pkg::tlb_load_t load,
  output logic                 fault,
  output cache_pkg::paddr_t    paddr
);

  localparam int IW = $clog2(TLB_ENTRIES);

  logic [IW-1:0] rd_index;
  logic [IW-1:0] ld_index;
  cache_pkg::tlb_entry_t entry;

  logic [TLB_ENTRIES-1:0] valid;
  logic valid_q;
  logic [cache_pkg::VTAG_BITS-1:0] vtag_q;
  logic [cache_pkg::PAGE_BITS-1:0] offset_q;

  assign rd_index = lookup_vaddr[cache_pkg::TLB_IDX_LSB +: IW];
  assign ld_index = load.index[IW-1:0];

  sync_ram #(
    .data_t (cache_pkg::tlb_entry_t),
    .DEPTH  (TLB_ENTRIES)
  ) u_entries (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_index),
    .rdata   (entry),
    .we      (load_we),
    .waddr   (ld_index),
    .wdata   (load.entry)
  );

  // valid bits, read alongside the entry RAM
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= valid[rd_index];
      if (load_we)
      begin
        valid[ld_index] <= 1'b1;
      end
    end
  end

  // tag and offset follow the RAM read by one cycle
  always_ff @(posedge CPU_CLK)
  begin
    vtag_q   <= lookup_vaddr[cache_pkg::VTAG_LSB +: cache_pkg::VTAG_BITS];
    offset_q <= lookup_vaddr[cache_pkg::PAGE_BITS-1:0];
  end

  assign fault = !valid_q || (entry.vtag != vtag_q);

  // frame number followed by page offset
  assign paddr.frame  = entry.frame;
  assign paddr.offset = offset_q;

endmodule

/* rtl/cache_array.sv */
`timescale 1ns/1ps

module cache_array #(
  parameter int CACHE_WORDS = 256
) (
  input  logic                           CPU_CLK,
  input  logic                           RST,
  input  cache_pkg::vaddr_t              lookup_vaddr,
  input  cache_pkg::line_tag_t           lookup_frame,
  output logic                           hit,
  output logic [31:0]                    rdata,
  input  logic                           fill_we,
  input  logic [$clog2(CACHE_WORDS)-1:0] fill_index,
  input  cache_pkg::line_tag_t           fill_tag,
  input  logic [31:0]                    fill_data
);

  localparam int IW = $clog2(CACHE_WORDS);

  logic [IW-1:0] rd_index;
  cache_pkg::line_tag_t tag_q;
  logic [CACHE_WORDS-1:0] valid;
  logic valid_q;

  // page offset bits are untranslated, so the virtual index is safe
  assign rd_index = lookup_vaddr[cache_pkg::WORD_LSB +: IW];

  sync_ram #(
    .data_t (logic [31:0]),
    .DEPTH  (CACHE_WORDS)
  ) u_data (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_index),
    .rdata   (rdata),
    .we      (fill_we),
    .waddr   (fill_index),
    .wdata   (fill_data)
  );

  sync_ram #(
    .data_t (cache_pkg::line_tag_t),
    .DEPTH  (CACHE_WORDS)
  ) u_tags (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_index),
    .rdata   (tag_q),
    .we      (fill_we),
    .waddr   (fill_index),
    .wdata   (fill_tag)
  );

  // per-word valid bits, set by every fill or write-hit update
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= valid[rd_index];
      if (fill_we)
      begin
        valid[fill_index] <= 1'b1;
      end
    end
  end

  // frame comes from the tlb in the same cycle
  assign hit = valid_q && (tag_q == lookup_frame);

endmodule

/* rtl/miss_sequencer.sv */
`timescale 1ns/1ps

module miss_sequencer #(
  parameter int CACHE_WORDS = 256,
  parameter int LINE_WORDS  = 2
) (
  input  logic                           CPU_CLK,
  input  logic                           RST,
  input  logic                           req_valid,
  input  cache_pkg::cpu_req_t            req,
  output cache_pkg::vaddr_t              lookup_vaddr,
  input  cache_pkg::lookup_t             look,
  output logic                           fill_we,
  output logic [$clog2(CACHE_WORDS)-1:0] fill_index,
  output cache_pkg::line_tag_t           fill_tag,
  output logic [31:0]                    fill_data,
  output logic                           mem_valid,
  output cache_pkg::mem_req_t            mem_req,
  input  logic                           mem_ack,
  input  logic [31:0]                    mem_rdata,
  output logic                           busy,
  output logic                           rsp_valid,
  output cache_pkg::cpu_rsp_t            rsp
);

  localparam int IW = $clog2(CACHE_WORDS);
  localparam int CW = $clog2(LINE_WORDS);
  localparam int LINE_LSB = cache_pkg::WORD_LSB + CW;
  localparam logic [cache_pkg::PAGE_BITS-1:0] LINE_MASK =
    ~cache_pkg::PAGE_BITS'((1 << LINE_LSB) - 1);
  localparam logic [CW-1:0] LAST_WORD = CW'(LINE_WORDS - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOOKUP,
    S_READ,
    S_WRITE
  } state_t;

  state_t state;
  logic [CW-1:0] word_cnt;
  logic accept;
  logic last_ack;

  cache_pkg::cpu_req_t req_q;
  cache_pkg::mem_req_t mem_req_q;
  logic wr_hit;

  // hits and faults finish in the lookup cycle without raising busy
  assign busy = (state == S_READ) || (state == S_WRITE) ||
                ((state == S_LOOKUP) && !look.fault && (req_q.write || !look.hit));

  assign accept = req_valid && !busy;
  assign last_ack = mem_ack && (word_cnt == LAST_WORD);

  // RAMs read the new address in the strobe cycle
  assign lookup_vaddr = accept ? req.addr : req_q.addr;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state     <= S_IDLE;
      word_cnt  <= '0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      rsp_valid <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (accept)
          begin
            state <= S_LOOKUP;
          end
        end
        S_LOOKUP:
        begin
          word_cnt <= '0;
          if (look.fault || (!req_q.write && look.hit))
          begin
            rsp_valid <= 1'b1;
            state     <= accept ? S_LOOKUP : S_IDLE;
          end
          else
          begin
            state <= req_q.write ? S_WRITE : S_READ;
          end
        end
        S_READ:
        begin
          if (mem_ack)
          begin
            word_cnt <= word_cnt + 1'b1;
          end
          if (last_ack)
          begin
            rsp_valid <= 1'b1;
            state     <= S_IDLE;
          end
        end
        default:
        begin
          if (mem_ack)
          begin
            rsp_valid <= 1'b1;
            state     <= S_IDLE;
          end
        end
      endcase
    end
  end

  // request, memory command and response payload
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      req_q <= req;
    end
    if (state == S_LOOKUP)
    begin
      wr_hit                 <= look.hit;
      mem_req_q.addr.frame   <= look.paddr.frame;
      mem_req_q.addr.offset  <= req_q.write ? look.paddr.offset
                                            : (look.paddr.offset & LINE_MASK);
      mem_req_q.write        <= req_q.write;
      mem_req_q.wdata        <= req_q.wdata;
      rsp.fault              <= look.fault;
      rsp.rdata              <= (look.fault || req_q.write) ? 32'h0 : look.rdata;
    end
    // keep only the word the CPU asked for
    if ((state == S_READ) && mem_ack &&
        (word_cnt == req_q.addr[cache_pkg::WORD_LSB +: CW]))
    begin
      rsp.rdata <= mem_rdata;
    end
  end

  assign mem_valid = (state == S_READ) || (state == S_WRITE);
  assign mem_req   = mem_req_q;

  // fills take every returned word, writes update only on a hit
  assign fill_we   = mem_ack && ((state == S_READ) || ((state == S_WRITE) && wr_hit));
  assign fill_tag  = mem_req_q.addr.frame;
  assign fill_data = (state == S_WRITE) ? req_q.wdata : mem_rdata;

  always_comb
  begin
    if (state == S_READ)
    begin
      fill_index = {req_q.addr[LINE_LSB +: IW - CW], word_cnt};
    end
    else
    begin
      fill_index = req_q.addr[cache_pkg::WORD_LSB +: IW];
    end
  end

endmodule

/* rtl/cache.sv */
`timescale 1ns/1ps

module cache #(
  parameter int CACHE_WORDS = 256,
  parameter int TLB_ENTRIES = 256,
  parameter int LINE_WORDS  = 2
) (
  input  logic                 CPU_CLK,
  input  logic                 RST,
  input  logic                 req_valid,
  input  cache_pkg::cpu_req_t  req,
  input  logic                 tlb_we,
  input  cache_pkg::tlb_load_t tlb_load,
  output logic                 busy,
  output logic                 rsp_valid,
  output cache_pkg::cpu_rsp_t  rsp,
  output logic                 mem_valid,
  output cache_pkg::mem_req_t  mem_req,
  input  logic                 mem_ack,
  input  logic [31:0]          mem_rdata
);

  localparam int IW = $clog2(CACHE_WORDS);

  cache_pkg::vaddr_t    lookup_vaddr;
  cache_pkg::lookup_t   look;
  cache_pkg::paddr_t    tlb_paddr;
  logic                 tlb_fault;
  logic                 ca_hit;
  logic [31:0]          ca_rdata;
  logic                 fill_we;
  logic [IW-1:0]        fill_index;
  cache_pkg::line_tag_t fill_tag;
  logic [31:0]          fill_data;

  tlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) u_tlb (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .lookup_vaddr (lookup_vaddr),
    .load_we      (tlb_we),
    .load         (tlb_load),
    .fault        (tlb_fault),
    .paddr        (tlb_paddr)
  );

  cache_array #(
    .CACHE_WORDS (CACHE_WORDS)
  ) u_array (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .lookup_vaddr (lookup_vaddr),
    .lookup_frame (tlb_paddr.frame),
    .hit          (ca_hit),
    .rdata        (ca_rdata),
    .fill_we      (fill_we),
    .fill_index   (fill_index),
    .fill_tag     (fill_tag),
    .fill_data    (fill_data)
  );

  // translation and array results for the sequencer
  assign look.hit   = ca_hit;
  assign look.fault = tlb_fault;
  assign look.paddr = tlb_paddr;
  assign look.rdata = ca_rdata;

  miss_sequencer #(
    .CACHE_WORDS (CACHE_WORDS),
    .LINE_WORDS  (LINE_WORDS)
  ) u_seq (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .req_valid    (req_valid),
    .req          (req),
    .lookup_vaddr (lookup_vaddr),
    .look         (look),
    .fill_we      (fill_we),
    .fill_index   (fill_index),
    .fill_tag     (fill_tag),
    .fill_data    (fill_data),
    .mem_valid    (mem_valid),
    .mem_req      (mem_req),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata),
    .busy         (busy),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp)
  );

endmodule

/* verification/cache_assert.sv */
`timescale 1ns/1ps

module cache_assert (
  input logic                CPU_CLK,
  input logic                RST,
  input logic                mem_valid,
  input cache_pkg::mem_req_t mem_req,
  input logic                mem_ack,
  input logic                rsp_valid,
  input cache_pkg::cpu_rsp_t rsp
);

  // command held until the memory answers
  mem_req_stable: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    ($past(mem_valid && !mem_ack) && mem_valid) |-> (mem_req == $past(mem_req))
  )
  else $error("memory request changed before its acknowledge");

  // response is a single-cycle pulse
  rsp_single_pulse: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    rsp_valid |-> !$past(rsp_valid)
  )
  else $error("response valid stayed high for two cycles");

  // faulting requests never reach memory
  fault_no_memory: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    (rsp_valid && rsp.fault) |-> !mem_valid
  )
  else $error("memory request active during a fault response");

endmodule

bind miss_sequencer cache_assert u_cache_assert (
  .CPU_CLK   (CPU_CLK),
  .RST       (RST),
  .mem_valid (mem_valid),
  .mem_req   (mem_req),
  .mem_ack   (mem_ack),
  .rsp_valid (rsp_valid),
  .rsp       (rsp)
);

/* verification/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

  localparam int NUM_OPS      = 19;
  localparam int RSP_TIMEOUT  = 200;
  localparam int QUIET_CYCLES = 6;

  typedef enum logic [1:0] {
    OP_LOAD,
    OP_READ,
    OP_WRITE,
    OP_BLOCKED
  } op_t;

  // data is the frame number for loads
  typedef struct packed {
    op_t         op;
    logic [31:0] vaddr;
    logic [31:0] data;
    logic        exp_fault;
    logic        exp_mem;
  } row_t;

  logic                 CPU_CLK;
  logic                 RST;
  logic                 req_valid;
  cache_pkg::cpu_req_t  req;
  logic                 tlb_we;
  cache_pkg::tlb_load_t tlb_load;
  logic                 busy;
  logic                 rsp_valid;
  cache_pkg::cpu_rsp_t  rsp;
  logic                 mem_valid;
  cache_pkg::mem_req_t  mem_req;
  logic                 mem_ack;
  logic [31:0]          mem_rdata;

  logic [31:0] lcg_state;
  logic [31:0] model_mem [1024];
  logic [31:0] shadow_mem [1024];
  logic [15:0] shadow_frame [256];
  cache_pkg::mem_req_t mem_log [$];
  row_t ops [NUM_OPS];

  cache_pkg::mem_req_t model_req;
  int model_words;
  int model_delay;
  logic [9:0] model_idx;

  cache #(
    .CACHE_WORDS (256),
    .TLB_ENTRIES (256),
    .LINE_WORDS  (2)
  ) cache_i (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .req_valid (req_valid),
    .req       (req),
    .tlb_we    (tlb_we),
    .tlb_load  (tlb_load),
    .busy      (busy),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .mem_valid (mem_valid),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // model word of a physical byte address
  function automatic logic [9:0] word_of(input cache_pkg::paddr_t p);
    return {p.frame[1:0], p.offset[9:2]};
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      fail_now($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  initial
  begin
    CPU_CLK = 1'b0;
    forever
    begin
      #5 CPU_CLK = ~CPU_CLK;
    end
  end

  // memory model, random ack delay of 0 to 3 cycles per word
  initial
  begin
    mem_ack   = 1'b0;
    mem_rdata = '0;
    lcg_state = 32'hc0e2_6938;
    for (int i = 0; i < 1024; i++)
      model_mem[i] = next_random() ^ 32'(i);
    forever
    begin
      @(posedge CPU_CLK);
      #1;
      if (RST && mem_valid)
      begin
        model_req = mem_req;
        mem_log.push_back(model_req);
        model_words = model_req.write ? 1 : 2;
        for (int w = 0; w < model_words; w++)
        begin
          model_delay = int'(next_random() >> 30);
          repeat (model_delay)
          begin
            @(posedge CPU_CLK);
            #1;
          end
          model_idx = word_of(model_req.addr) + 10'(w);
          if (model_req.write)
            model_mem[model_idx] = model_req.wdata;
          else
            mem_rdata = model_mem[model_idx];
          mem_ack = 1'b1;
          @(posedge CPU_CLK);
          #1;
          mem_ack = 1'b0;
        end
      end
    end
  end

  task automatic fill_table();
    ops[0]  = '{OP_READ,    32'h048C_1410, 32'h0000_0000, 1'b1, 1'b0};
    ops[1]  = '{OP_LOAD,    32'h048C_1410, 32'h0000_0001, 1'b0, 1'b0};
    ops[2]  = '{OP_READ,    32'h048C_1414, 32'h0000_0000, 1'b0, 1'b1};
    ops[3]  = '{OP_READ,    32'h048C_1410, 32'h0000_0000, 1'b0, 1'b0};
    ops[4]  = '{OP_READ,    32'h048C_1414, 32'h0000_0000, 1'b0, 1'b0};
    ops[5]  = '{OP_WRITE,   32'h048C_1414, 32'hA5A5_0001, 1'b0, 1'b1};
    ops[6]  = '{OP_READ,    32'h048C_1414, 32'h0000_0000, 1'b0, 1'b0};
    ops[7]  = '{OP_READ,    32'h048C_1520, 32'h0000_0000, 1'b0, 1'b1};
    ops[8]  = '{OP_WRITE,   32'h048C_1528, 32'h5A5A_0002, 1'b0, 1'b1};
    ops[9]  = '{OP_READ,    32'h048C_1528, 32'h0000_0000, 1'b0, 1'b1};
    ops[10] = '{OP_LOAD,    32'h048C_1410, 32'h0000_0002, 1'b0, 1'b0};
    ops[11] = '{OP_READ,    32'h048C_1410, 32'h0000_0000, 1'b0, 1'b1};
    ops[12] = '{OP_BLOCKED, 32'h048C_1430, 32'hDEAD_BEEF, 1'b0, 1'b1};
    ops[13] = '{OP_READ,    32'h048C_1434, 32'h0000_0000, 1'b0, 1'b0};
    ops[14] = '{OP_WRITE,   32'h0000_0800, 32'h1234_5678, 1'b1, 1'b0};
    ops[15] = '{OP_LOAD,    32'hFFFC_A8C4, 32'h0000_0003, 1'b0, 1'b0};
    ops[16] = '{OP_READ,    32'hFFFC_A8C4, 32'h0000_0000, 1'b0, 1'b1};
    ops[17] = '{OP_READ,    32'hFFFC_A8C0, 32'h0000_0000, 1'b0, 1'b0};
    ops[18] = '{OP_READ,    32'h0000_1410, 32'h0000_0000, 1'b1, 1'b0};
  endtask

  task automatic load_translation(input row_t r);
    tlb_load.index       = r.vaddr[17:10];
    tlb_load.entry.vtag  = r.vaddr[31:18];
    tlb_load.entry.frame = r.data[15:0];
    tlb_we = 1'b1;
    @(posedge CPU_CLK);
    #1;
    tlb_we = 1'b0;
    shadow_frame[r.vaddr[17:10]] = r.data[15:0];
  endtask

  task automatic run_request(input row_t r);
    cache_pkg::paddr_t   exp_paddr;
    cache_pkg::mem_req_t got;
    int   cycles;
    int   log_before;
    logic saw_busy;
    logic extra_sent;

    exp_paddr.frame  = shadow_frame[r.vaddr[17:10]];
    exp_paddr.offset = r.vaddr[9:0];
    log_before = mem_log.size();
    saw_busy   = 1'b0;
    extra_sent = 1'b0;
    req_valid  = 1'b1;
    req.addr   = r.vaddr;
    req.write  = (r.op == OP_WRITE);
    req.wdata  = r.data;
    @(posedge CPU_CLK);
    #1;
    req_valid = 1'b0;
    cycles = 1;
    while (!rsp_valid)
    begin
      if (busy)
        saw_busy = 1'b1;
      // second strobe while busy, must be dropped
      if ((r.op == OP_BLOCKED) && busy && !extra_sent)
      begin
        req_valid  = 1'b1;
        req.addr   = r.vaddr + 32'd4;
        req.write  = 1'b1;
        extra_sent = 1'b1;
      end
      if (cycles >= RSP_TIMEOUT)
        fail_now("the cache gave no response within the timeout");
      @(posedge CPU_CLK);
      #1;
      req_valid = 1'b0;
      cycles++;
    end
    check_value("busy", 32'(busy), 32'h0);
    check_value("rsp.fault", 32'(rsp.fault), 32'(r.exp_fault));
    check_value("memory request count", 32'(mem_log.size() - log_before), 32'(r.exp_mem));
    if (!r.exp_mem)
    begin
      check_value("response latency", 32'(cycles), 32'd2);
      check_value("busy during lookup", 32'(saw_busy), 32'h0);
    end
    else
    begin
      got = mem_log[log_before];
      check_value("mem_req.write", 32'(got.write), 32'(r.op == OP_WRITE));
      if (r.op == OP_WRITE)
      begin
        check_value("mem_req.addr", 32'(got.addr), 32'(exp_paddr));
        check_value("mem_req.wdata", got.wdata, r.data);
      end
      else
      begin
        check_value("mem_req.addr", 32'(got.addr),
                    32'({exp_paddr.frame, exp_paddr.offset[9:3], 3'b000}));
      end
    end
    if ((r.op != OP_WRITE) && !r.exp_fault)
      check_value("rsp.rdata", rsp.rdata, shadow_mem[word_of(exp_paddr)]);
    if ((r.op == OP_WRITE) && !r.exp_fault)
      shadow_mem[word_of(exp_paddr)] = r.data;
    if (r.op == OP_BLOCKED)
    begin
      if (!extra_sent)
        fail_now("busy never rose, so no request could be strobed while busy");
      repeat (QUIET_CYCLES)
      begin
        @(posedge CPU_CLK);
        #1;
        if (rsp_valid)
          fail_now("a request strobed while busy got a response");
      end
      check_value("memory request count", 32'(mem_log.size() - log_before), 32'd1);
    end
  endtask

  initial
  begin
    RST       = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    tlb_we    = 1'b0;
    tlb_load  = '0;
    for (int i = 0; i < 256; i++)
    begin
      shadow_frame[i] = '0;
    end
    fill_table();
    repeat (4) @(posedge CPU_CLK);
    #1;
    RST = 1'b1;
    // preset contents as seen by the model
    for (int i = 0; i < 1024; i++)
      shadow_mem[i] = model_mem[i];
    check_value("busy", 32'(busy), 32'h0);
    check_value("rsp_valid", 32'(rsp_valid), 32'h0);
    check_value("mem_valid", 32'(mem_valid), 32'h0);
    for (int n = 0; n < NUM_OPS; n++)
    begin
      if (ops[n].op == OP_LOAD)
        load_translation(ops[n]);
      else
        run_request(ops[n]);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

/* project.f */
rtl/cache_pkg.sv
rtl/sync_ram.sv
rtl/tlb.sv
rtl/cache_array.sv
rtl/miss_sequencer.sv
rtl/cache.sv
verification/cache_assert.sv
verification/tb_cache.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cache -f project.f -o sim_cache
	./obj_dir/sim_cache

clean:
	rm -rf obj_dir
